// ==== Bender.yml ====
package:
  name: list_sel

sources:
  - list_sel_pkg.sv
  - list_sel_mem_bank.sv
  - list_sel_mem_rf_2048x16.sv
  - list_sel_enq.sv
  - list_sel_deq.sv
  - list_sel_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_list_sel_checker.sv
      - tb_list_sel.sv

// ==== list.f ====
list_sel_pkg.sv
list_sel_mem_bank.sv
list_sel_mem_rf_2048x16.sv
list_sel_enq.sv
list_sel_deq.sv
list_sel_top.sv
tb_clk_gen.sv
tb_list_sel_checker.sv
tb_list_sel.sv

// ==== list_sel_deq.sv ====
`timescale 1ns/1ps

module list_sel_deq (
     input  logic                   rclk
    ,input  logic                   rclk_rst_n
    ,input  logic                   pop
    ,input  list_sel_pkg::list_ptr_t wr_ptr
    ,input  list_sel_pkg::mem_data_t rdata
    ,output list_sel_pkg::mem_rd_t   rd
    ,output list_sel_pkg::list_ptr_t rd_ptr
    ,output list_sel_pkg::mem_data_t deq_data
    ,output logic                   deq_valid
    ,output logic                   deq_drop
);

    // Queue is empty
    logic empty;

    // Pop that is turned into a read
    logic pop_ok;

    // Read was issued last cycle, data is now at the memory output
    logic rd_pend_q;

    // Pop was rejected last cycle
    logic rej_q;

    // Empty when both pointers agree, wrap bit included
    assign empty = (wr_ptr == rd_ptr);

    assign pop_ok = pop && !empty;

    // ******************************
    // Read request
    // ******************************

    // Issued in the same cycle as the pop, the memory samples it at the next edge
    assign rd.re    = pop_ok;
    assign rd.raddr = rd_ptr[list_sel_pkg::mem_addr_w-1:0];

    // Pointer moves on the edge that samples the read
    always_ff @(posedge rclk or negedge rclk_rst_n) begin
        if (!rclk_rst_n) begin
            rd_ptr <= '0;
        end else if (pop_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // ******************************
    // Returned data
    // ******************************

    // One cycle after the read the memory output is stable and is captured here
    always_ff @(posedge rclk or negedge rclk_rst_n) begin
        if (!rclk_rst_n) begin
            rd_pend_q <= 1'b0;
            rej_q     <= 1'b0;
            deq_valid <= 1'b0;
            deq_drop  <= 1'b0;
            deq_data  <= '0;
        end else begin
            rd_pend_q <= pop_ok;
            rej_q     <= pop && empty;
            deq_valid <= rd_pend_q;
            // The drop pulse takes the same slot a valid output would have taken
            deq_drop  <= rej_q;
            if (rd_pend_q) begin
                deq_data <= rdata;
            end
        end
    end

endmodule

// ==== list_sel_enq.sv ====
`timescale 1ns/1ps

module list_sel_enq (
     input  logic                   rclk
    ,input  logic                   rclk_rst_n
    ,input  logic                   push
    ,input  list_sel_pkg::mem_data_t push_data
    ,input  list_sel_pkg::list_ptr_t rd_ptr
    ,output list_sel_pkg::mem_wr_t   wr
    ,output list_sel_pkg::list_ptr_t wr_ptr
    ,output logic                   enq_drop
);

    // Queue is full
    logic full;

    // Push that is turned into a write
    logic push_ok;

    // Rejected push, turned into the drop pulse one cycle later
    logic rej_q;

    // Full when the addresses meet but the wrap bits differ
    assign full = (wr_ptr[list_sel_pkg::mem_addr_w-1:0] == rd_ptr[list_sel_pkg::mem_addr_w-1:0])
                && (wr_ptr[list_sel_pkg::mem_addr_w] != rd_ptr[list_sel_pkg::mem_addr_w]);

    assign push_ok = push && !full;

    // ******************************
    // Write request and pointer
    // ******************************

    // The request is registered here and the memory performs it on the next edge
    // The pointer moves now, so the consumer sees the entry one cycle later
    always_ff @(posedge rclk or negedge rclk_rst_n) begin
        if (!rclk_rst_n) begin
            wr     <= '0;
            wr_ptr <= '0;
        end else begin
            wr.we <= push_ok;
            if (push_ok) begin
                wr.waddr <= wr_ptr[list_sel_pkg::mem_addr_w-1:0];
                wr.wdata <= push_data;
                wr_ptr   <= wr_ptr + 1'b1;
            end
        end
    end

    // ******************************
    // Drop pulse
    // ******************************

    // Two stages so the pulse lines up with the edge the write would have landed
    always_ff @(posedge rclk or negedge rclk_rst_n) begin
        if (!rclk_rst_n) begin
            rej_q    <= 1'b0;
            enq_drop <= 1'b0;
        end else begin
            rej_q    <= push && full;
            enq_drop <= rej_q;
        end
    end

endmodule

// ==== list_sel_mem_bank.sv ====
`timescale 1ns/1ps

module list_sel_mem_bank (
     input  logic                    rclk
    ,input  logic                    rclk_rst_n
    ,input  logic                    we
    ,input  list_sel_pkg::bank_addr_t waddr
    ,input  list_sel_pkg::mem_data_t  wdata
    ,input  logic                    re
    ,input  list_sel_pkg::bank_addr_t raddr
    ,input  logic                    pgcb_isol_en
    ,input  logic                    pwr_enable_b_in
    ,output list_sel_pkg::mem_data_t  rdata
    ,output logic                    pwr_enable_b_out
);

    // Storage array of this bank
    list_sel_pkg::mem_data_t mem [list_sel_pkg::bank_depth];

    // Read data register, loaded only when a read is issued
    list_sel_pkg::mem_data_t rdata_q;

    // Registered power enable, high means the bank is asleep
    logic pwr_q;

    // ******************************
    // Power enable chain stage
    // ******************************

    // The bank comes out of reset asleep and wakes one cycle after its input drops
    always_ff @(posedge rclk or negedge rclk_rst_n) begin
        if (!rclk_rst_n) begin
            pwr_q <= 1'b1;
        end else begin
            pwr_q <= pwr_enable_b_in;
        end
    end

    // The same registered value feeds the next bank in the chain
    assign pwr_enable_b_out = pwr_q;

    // ******************************
    // Array write and read
    // ******************************

    // A sleeping bank drops writes but keeps what it already holds
    always_ff @(posedge rclk) begin
        if (we && !pwr_q) begin
            mem[waddr] <= wdata;
        end
    end

    // Reads load zero while asleep
    // A read hitting the address written on the same edge takes the new data
    always_ff @(posedge rclk or negedge rclk_rst_n) begin
        if (!rclk_rst_n) begin
            rdata_q <= '0;
        end else if (re) begin
            if (pwr_q) begin
                rdata_q <= '0;
            end else if (we && (waddr == raddr)) begin
                rdata_q <= wdata;
            end else begin
                rdata_q <= mem[raddr];
            end
        end
    end

    // Isolation clamps the output without touching the held value
    assign rdata = pgcb_isol_en ? '0 : rdata_q;

endmodule

// ==== list_sel_mem_rf_2048x16.sv ====
`timescale 1ns/1ps

module list_sel_mem_rf_2048x16 (
     input  logic                   rclk
    ,input  logic                   rclk_rst_n
    ,input  list_sel_pkg::mem_wr_t   wr
    ,input  list_sel_pkg::mem_rd_t   rd
    ,input  logic                   pgcb_isol_en
    ,input  logic                   pwr_enable_b_in
    ,output list_sel_pkg::mem_data_t rdata
    ,output logic                   pwr_enable_b_out
);

    // Read data coming back from each bank
    list_sel_pkg::mem_data_t rdata_b0;
    list_sel_pkg::mem_data_t rdata_b1;

    // Per-bank write and read enables, bit 1 is the upper bank
    logic [1:0] we_sel;
    logic [1:0] re_sel;

    // Bank that answered the last read
    logic rd_bank_q;

    // Power enable between bank 0 and bank 1
    logic pwr_mid;

    // ******************************
    // Bank decode
    // ******************************

    // The top address bit splits the space into two halves
    assign we_sel[1] = wr.we &  wr.waddr[list_sel_pkg::mem_addr_w-1];
    assign we_sel[0] = wr.we & ~wr.waddr[list_sel_pkg::mem_addr_w-1];
    assign re_sel[1] = rd.re &  rd.raddr[list_sel_pkg::mem_addr_w-1];
    assign re_sel[0] = rd.re & ~rd.raddr[list_sel_pkg::mem_addr_w-1];

    // Remember which bank was read, so the mux follows the bank data registers
    always_ff @(posedge rclk or negedge rclk_rst_n) begin
        if (!rclk_rst_n) begin
            rd_bank_q <= 1'b0;
        end else if (rd.re) begin
            rd_bank_q <= rd.raddr[list_sel_pkg::mem_addr_w-1];
        end
    end

    // ******************************
    // Banks
    // ******************************

    // Lower half, first stage of the power chain
    list_sel_mem_bank i_rf_b0 (
         .rclk             (rclk)
        ,.rclk_rst_n       (rclk_rst_n)
        ,.we               (we_sel[0])
        ,.waddr            (wr.waddr[list_sel_pkg::bank_addr_w-1:0])
        ,.wdata            (wr.wdata)
        ,.re               (re_sel[0])
        ,.raddr            (rd.raddr[list_sel_pkg::bank_addr_w-1:0])
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.rdata            (rdata_b0)
        ,.pwr_enable_b_out (pwr_mid)
    );

    // Upper half, second stage of the power chain
    list_sel_mem_bank i_rf_b1 (
         .rclk             (rclk)
        ,.rclk_rst_n       (rclk_rst_n)
        ,.we               (we_sel[1])
        ,.waddr            (wr.waddr[list_sel_pkg::bank_addr_w-1:0])
        ,.wdata            (wr.wdata)
        ,.re               (re_sel[1])
        ,.raddr            (rd.raddr[list_sel_pkg::bank_addr_w-1:0])
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_mid)
        ,.rdata            (rdata_b1)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // Output mux, the value holds until the next read changes bank or data
    assign rdata = rd_bank_q ? rdata_b1 : rdata_b0;

endmodule

// ==== list_sel_pkg.sv ====
package list_sel_pkg;

    // ******************************
    // Geometry of the register file
    // ******************************

    // Total number of queue entries across both banks
    localparam int mem_depth = 2048;

    // Each physical bank holds half of the entries
    localparam int bank_depth = 1024;

    // Width of one stored entry
    localparam int mem_data_w = 16;

    // Address widths follow from the depths
    localparam int mem_addr_w  = $clog2(mem_depth);
    localparam int bank_addr_w = $clog2(bank_depth);

    // ******************************
    // Vector types
    // ******************************

    // One stored entry
    typedef logic [mem_data_w-1:0] mem_data_t;

    // Full address, the top bit picks the bank
    typedef logic [mem_addr_w-1:0] mem_addr_t;

    // Address inside a single bank
    typedef logic [bank_addr_w-1:0] bank_addr_t;

    // Queue pointer is the address plus one wrap bit on top
    typedef logic [mem_addr_w:0] list_ptr_t;

    // ******************************
    // Request structs
    // ******************************

    // Write request from the producer, performed at the next edge
    typedef struct packed {
        logic      we;
        mem_addr_t waddr;
        mem_data_t wdata;
    } mem_wr_t;

    // Read request from the consumer, sampled at the edge it is issued
    typedef struct packed {
        logic      re;
        mem_addr_t raddr;
    } mem_rd_t;

endpackage

// ==== list_sel_top.sv ====
`timescale 1ns/1ps

module list_sel_top (
     input  logic                   rclk
    ,input  logic                   rclk_rst_n
    ,input  logic                   push
    ,input  list_sel_pkg::mem_data_t push_data
    ,input  logic                   pop
    ,input  logic                   pgcb_isol_en
    ,input  logic                   pwr_enable_b_in
    ,output list_sel_pkg::mem_data_t deq_data
    ,output logic                   deq_valid
    ,output logic                   enq_drop
    ,output logic                   deq_drop
    ,output logic                   pwr_enable_b_out
);

    // Write request from producer to buffer
    list_sel_pkg::mem_wr_t wr;

    // Read request from consumer to buffer
    list_sel_pkg::mem_rd_t rd;

    // Read data from buffer to consumer
    list_sel_pkg::mem_data_t rdata;

    // Pointers exchanged so each side can judge full or empty on its own
    list_sel_pkg::list_ptr_t wr_ptr;
    list_sel_pkg::list_ptr_t rd_ptr;

    // ******************************
    // Producer
    // ******************************

    list_sel_enq i_enq (
         .rclk       (rclk)
        ,.rclk_rst_n (rclk_rst_n)
        ,.push       (push)
        ,.push_data  (push_data)
        ,.rd_ptr     (rd_ptr)
        ,.wr         (wr)
        ,.wr_ptr     (wr_ptr)
        ,.enq_drop   (enq_drop)
    );

    // ******************************
    // Buffer
    // ******************************

    list_sel_mem_rf_2048x16 i_mem (
         .rclk             (rclk)
        ,.rclk_rst_n       (rclk_rst_n)
        ,.wr               (wr)
        ,.rd               (rd)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.rdata            (rdata)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // ******************************
    // Consumer
    // ******************************

    list_sel_deq i_deq (
         .rclk       (rclk)
        ,.rclk_rst_n (rclk_rst_n)
        ,.pop        (pop)
        ,.wr_ptr     (wr_ptr)
        ,.rdata      (rdata)
        ,.rd         (rd)
        ,.rd_ptr     (rd_ptr)
        ,.deq_data   (deq_data)
        ,.deq_valid  (deq_valid)
        ,.deq_drop   (deq_drop)
    );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
     output logic rclk
    ,output logic rclk_rst_n
);

    // Free running clock with a 4 ns period
    initial begin
        rclk = 1'b0;
        forever #2 rclk = ~rclk;
    end

    // Reset is held low over four rising edges
    // Release comes just after the last one, like every other input
    initial begin
        rclk_rst_n = 1'b0;
        repeat (4) @(posedge rclk);
        #1 rclk_rst_n = 1'b1;
    end

endmodule

// ==== tb_list_sel.sv ====
`timescale 1ns/1ps

module tb_list_sel;

    // One row of the stimulus table
    typedef struct packed {
        logic [127:0] name;
        logic [15:0]  push_cnt;
        logic [15:0]  pop_cnt;
        logic         interleave;
        logic         isol;
        logic         pwr_b;
        logic [15:0]  exp_enq_drops;
        logic [15:0]  exp_deq_drops;
    } test_row_t;

    localparam int num_tests     = 7;
    // Power chain needs two edges plus a little slack
    localparam int settle_cycles = 4;

    test_row_t tests [num_tests];

    logic                    rclk;
    logic                    rclk_rst_n;
    logic                    push;
    list_sel_pkg::mem_data_t push_data;
    logic                    pop;
    logic                    pgcb_isol_en;
    logic                    pwr_enable_b_in;
    list_sel_pkg::mem_data_t deq_data;
    logic                    deq_valid;
    logic                    enq_drop;
    logic                    deq_drop;
    logic                    pwr_enable_b_out;

    // Control towards the checker
    logic [127:0] test_name;
    logic         test_start;
    logic         test_done;
    int           exp_enq_drops;
    int           exp_deq_drops;
    logic         idle;
    int           err_count;
    int           test_count;
    int           fail_count;

    integer seed;
    logic   table_ready;

    tb_clk_gen i_clk_gen (
         .rclk       (rclk)
        ,.rclk_rst_n (rclk_rst_n)
    );

    list_sel_top dut0 (
         .rclk             (rclk)
        ,.rclk_rst_n       (rclk_rst_n)
        ,.push             (push)
        ,.push_data        (push_data)
        ,.pop              (pop)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.deq_data         (deq_data)
        ,.deq_valid        (deq_valid)
        ,.enq_drop         (enq_drop)
        ,.deq_drop         (deq_drop)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    tb_list_sel_checker i_checker (
         .rclk             (rclk)
        ,.rclk_rst_n       (rclk_rst_n)
        ,.push             (push)
        ,.push_data        (push_data)
        ,.pop              (pop)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.deq_data         (deq_data)
        ,.deq_valid        (deq_valid)
        ,.enq_drop         (enq_drop)
        ,.deq_drop         (deq_drop)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.test_name        (test_name)
        ,.test_start       (test_start)
        ,.test_done        (test_done)
        ,.exp_enq_drops    (exp_enq_drops)
        ,.exp_deq_drops    (exp_deq_drops)
        ,.idle             (idle)
        ,.err_count        (err_count)
        ,.test_count       (test_count)
        ,.fail_count       (fail_count)
    );

    // ******************************
    // Stimulus table
    // ******************************

    task automatic set_row(input int idx, input logic [127:0] name, input int n_push,
                           input int n_pop, input logic inter, input logic isol,
                           input logic pwr_b, input int e_enq, input int e_deq);
        tests[idx].name          = name;
        tests[idx].push_cnt      = n_push;
        tests[idx].pop_cnt       = n_pop;
        tests[idx].interleave    = inter;
        tests[idx].isol          = isol;
        tests[idx].pwr_b         = pwr_b;
        tests[idx].exp_enq_drops = e_enq;
        tests[idx].exp_deq_drops = e_deq;
    endtask

    // Rows run in order and each leaves the queue as the next expects it
    task automatic fill_table();
        set_row(0, "round_trip", 600, 600, 1'b1, 1'b0, 1'b0, 0, 0);
        // Starts at entry 600, runs through bank 1 and wraps to the start
        set_row(1, "bank_cross", 1500, 1500, 1'b0, 1'b0, 1'b0, 0, 0);
        set_row(2, "full_empty", 2049, 2049, 1'b0, 1'b0, 1'b0, 1, 1);
        // Starts at entry 52 and leaves both pointers at entry 1020
        set_row(3, "isolation", 968, 968, 1'b1, 1'b1, 1'b0, 0, 0);
        // The fill spans entries 1020 to 1035 across the bank boundary
        set_row(4, "pwr_fill", 16, 0, 1'b0, 1'b0, 1'b0, 0, 0);
        // Pushes while asleep land in bank 1 and are lost
        // The pops read the first half of the fill from both sleeping banks
        set_row(5, "pwr_sleep", 8, 8, 1'b0, 1'b0, 1'b1, 0, 0);
        set_row(6, "pwr_wake", 0, 16, 1'b0, 1'b0, 1'b0, 0, 0);
    endtask

    // Interleaved pops trail the pushes by one cycle
    function automatic int row_cycles(input test_row_t row);
        int strobes;
        if (row.interleave) begin
            strobes = (row.push_cnt > row.pop_cnt) ? int'(row.push_cnt) : row.pop_cnt + 1;
        end else begin
            strobes = row.push_cnt + row.pop_cnt;
        end
        return strobes + settle_cycles + 10;
    endfunction

    // ******************************
    // Driving
    // ******************************

    task automatic drive_cycle(input logic do_push, input logic do_pop);
        integer rnd;
        @(posedge rclk);
        #1;
        rnd       = $random(seed);
        push      = do_push;
        pop       = do_pop;
        push_data = do_push ? rnd[15:0] : '0;
    endtask

    task automatic run_test(input test_row_t row);
        int c;
        int steps;
        @(posedge rclk);
        #1;
        test_name       = row.name;
        exp_enq_drops   = row.exp_enq_drops;
        exp_deq_drops   = row.exp_deq_drops;
        pgcb_isol_en    = row.isol;
        pwr_enable_b_in = row.pwr_b;
        test_start      = 1'b1;
        @(posedge rclk);
        #1 test_start = 1'b0;
        repeat (settle_cycles) @(posedge rclk);
        if (row.interleave) begin
            steps = (row.push_cnt > row.pop_cnt) ? int'(row.push_cnt) : row.pop_cnt + 1;
            for (c = 0; c < steps; c++) begin
                drive_cycle(c < row.push_cnt, (c >= 1) && (c <= row.pop_cnt));
            end
        end else begin
            for (c = 0; c < row.push_cnt; c++) begin
                drive_cycle(1'b1, 1'b0);
            end
            for (c = 0; c < row.pop_cnt; c++) begin
                drive_cycle(1'b0, 1'b1);
            end
        end
        drive_cycle(1'b0, 1'b0);
        // Wait until the checker has seen every expected output
        @(posedge rclk);
        while (!idle) begin
            @(posedge rclk);
        end
        #1 test_done = 1'b1;
        @(posedge rclk);
        #1 test_done = 1'b0;
    endtask

    initial begin
        push            = 1'b0;
        push_data       = '0;
        pop             = 1'b0;
        pgcb_isol_en    = 1'b0;
        pwr_enable_b_in = 1'b0;
        test_name       = '0;
        test_start      = 1'b0;
        test_done       = 1'b0;
        exp_enq_drops   = 0;
        exp_deq_drops   = 0;
        seed            = 94;
        table_ready     = 1'b0;
        fill_table();
        table_ready = 1'b1;
        wait (rclk_rst_n === 1'b1);
        for (int i = 0; i < num_tests; i++) begin
            run_test(tests[i]);
        end
        $display("Tests run %0d, failed %0d, errors %0d", test_count, fail_count, err_count);
        if ((fail_count == 0) && (err_count == 0) && (test_count == num_tests)) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // ******************************
    // Watchdog
    // ******************************

    // Limit counts 4 ns cycles over the table length plus reset and margin
    initial begin
        int limit;
        wait (table_ready === 1'b1);
        limit = 200;
        for (int i = 0; i < num_tests; i++) begin
            limit = limit + row_cycles(tests[i]);
        end
        #(limit * 4);
        $display("Timeout: the tests did not finish within %0d clock cycles", limit);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== tb_list_sel_checker.sv ====
`timescale 1ns/1ps

module tb_list_sel_checker (
     input  logic                    rclk
    ,input  logic                    rclk_rst_n
    ,input  logic                    push
    ,input  list_sel_pkg::mem_data_t push_data
    ,input  logic                    pop
    ,input  logic                    pgcb_isol_en
    ,input  logic                    pwr_enable_b_in
    ,input  list_sel_pkg::mem_data_t deq_data
    ,input  logic                    deq_valid
    ,input  logic                    enq_drop
    ,input  logic                    deq_drop
    ,input  logic                    pwr_enable_b_out
    ,input  logic [127:0]            test_name
    ,input  logic                    test_start
    ,input  logic                    test_done
    ,input  int                      exp_enq_drops
    ,input  int                      exp_deq_drops
    ,output logic                    idle
    ,output int                      err_count
    ,output int                      test_count
    ,output int                      fail_count
);

    // What one clock edge should show on the DUT outputs
    typedef struct packed {
        logic                    valid;
        list_sel_pkg::mem_data_t data;
        logic                    enq_drop;
        logic                    deq_drop;
    } outcome_t;

    // Reference storage, indexed by the full address
    list_sel_pkg::mem_data_t model_mem [list_sel_pkg::mem_depth];

    // Queue occupancy and ring positions of the model
    int count;
    int head;
    int tail;

    // Accepted push whose write lands on the following edge
    logic                    wr_pend;
    int                      wr_pend_addr;
    list_sel_pkg::mem_data_t wr_pend_data;

    // Sleep state of each bank, high means asleep
    logic bank0_sleep;
    logic bank1_sleep;

    // Stage one holds the edge that sampled a strobe, stage two the edge after it
    outcome_t stage1;
    outcome_t stage2;

    // Per-test tallies
    int test_errs;
    int enq_seen;
    int deq_seen;

    initial begin
        err_count  = 0;
        test_count = 0;
        fail_count = 0;
        test_errs  = 0;
        enq_seen   = 0;
        deq_seen   = 0;
    end

    // Nothing is in flight once both stages are quiet
    assign idle = !(stage1.valid || stage1.enq_drop || stage1.deq_drop
                 || stage2.valid || stage2.enq_drop || stage2.deq_drop);

    // ******************************
    // Reference model
    // ******************************

    // The top address bit picks the bank
    function automatic logic bank_asleep(input int addr);
        return (addr >= list_sel_pkg::bank_depth) ? bank1_sleep : bank0_sleep;
    endfunction

    task automatic reset_model();
        count       = 0;
        head        = 0;
        tail        = 0;
        wr_pend     = 1'b0;
        bank0_sleep = 1'b1;
        bank1_sleep = 1'b1;
        stage1      = '0;
        stage2      = '0;
    endtask

    task automatic report_mismatch(input string what, input logic [15:0] exp_val,
                                   input logic [15:0] act_val);
        $display("MISMATCH %0s %0s expected %h actual %h", test_name, what, exp_val, act_val);
        err_count++;
        test_errs++;
    endtask

    // Outputs seen now are the result of the edge held in stage two
    task automatic check_outputs();
        if (deq_valid !== stage2.valid) begin
            report_mismatch("deq_valid", stage2.valid, deq_valid);
        end else if (stage2.valid && (deq_data !== stage2.data)) begin
            report_mismatch("deq_data", stage2.data, deq_data);
        end
        if (enq_drop !== stage2.enq_drop) begin
            report_mismatch("enq_drop", stage2.enq_drop, enq_drop);
        end
        if (deq_drop !== stage2.deq_drop) begin
            report_mismatch("deq_drop", stage2.deq_drop, deq_drop);
        end
        // The chain output is the sleep state of the last bank
        if (pwr_enable_b_out !== bank1_sleep) begin
            report_mismatch("pwr_enable_b_out", bank1_sleep, pwr_enable_b_out);
        end
        if (enq_drop === 1'b1) begin
            enq_seen++;
        end
        if (deq_drop === 1'b1) begin
            deq_seen++;
        end
    endtask

    // Applies what the coming edge does with the inputs held now
    task automatic advance_model();
        logic                    push_ok;
        logic                    pop_ok;
        list_sel_pkg::mem_data_t rd_val;
        // Returned data is captured at this edge, so isolation is judged here
        stage2 = stage1;
        if (pgcb_isol_en) begin
            stage2.data = '0;
        end
        // Full and empty both look at the occupancy before the edge
        push_ok = push && (count < list_sel_pkg::mem_depth);
        pop_ok  = pop && (count > 0);
        // Last cycle's write lands first, so a read of the same entry sees it
        if (wr_pend && !bank_asleep(wr_pend_addr)) begin
            model_mem[wr_pend_addr] = wr_pend_data;
        end
        rd_val = '0;
        if (pop_ok && !bank_asleep(head)) begin
            rd_val = model_mem[head];
        end
        stage1.valid    = pop_ok;
        stage1.data     = rd_val;
        stage1.enq_drop = push && !push_ok;
        stage1.deq_drop = pop && !pop_ok;
        wr_pend = push_ok;
        if (push_ok) begin
            wr_pend_addr = tail;
            wr_pend_data = push_data;
            tail = (tail + 1) % list_sel_pkg::mem_depth;
        end
        if (pop_ok) begin
            head = (head + 1) % list_sel_pkg::mem_depth;
        end
        count = count + push_ok - pop_ok;
        // One register per bank in the power chain
        bank1_sleep = bank0_sleep;
        bank0_sleep = pwr_enable_b_in;
    endtask

    // ******************************
    // Per-test report
    // ******************************

    task automatic report_test();
        if (enq_seen != exp_enq_drops) begin
            $display("MISMATCH %0s enq_drop count expected %0d actual %0d",
                     test_name, exp_enq_drops, enq_seen);
            err_count++;
            test_errs++;
        end
        if (deq_seen != exp_deq_drops) begin
            $display("MISMATCH %0s deq_drop count expected %0d actual %0d",
                     test_name, exp_deq_drops, deq_seen);
            err_count++;
            test_errs++;
        end
        test_count++;
        if (test_errs == 0) begin
            $display("PASS %0s", test_name);
        end else begin
            $display("FAIL %0s with %0d errors", test_name, test_errs);
            fail_count++;
        end
    endtask

    // Inputs and outputs are both settled at the falling edge
    always @(negedge rclk) begin
        if (test_start) begin
            test_errs = 0;
            enq_seen  = 0;
            deq_seen  = 0;
        end
        if (!rclk_rst_n) begin
            reset_model();
        end else begin
            check_outputs();
            advance_model();
        end
        if (test_done) begin
            report_test();
        end
    end

endmodule
